// ==== Makefile ====
# verilator flow for the i/o page slave testbench.

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module tb_iopage -f flist.f

sim:
	verilator --binary --timing --assert --top-module tb_iopage -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_iopage +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bootrom/bootrom.sv ====
// rk11 boot rom on the i/o page, octal 13000 to 13776.
// combinational word read; byte selection is done by the response stage.
`timescale 1ns/1ps

module bootrom
(
   input  iopage_pkg::dev_req_t dreq,
   output iopage_pkg::dev_rsp_t rsp
);

   iopage_pkg::iopage_addr_t offset;         // byte offset into the window.
   iopage_pkg::rom_idx_t     idx;            // word offset into the table.
   iopage_pkg::word_t        fetch;          // table word at idx.
   logic                     in_range;

   assign in_range = (dreq.addr >= iopage_pkg::ROM_FIRST) &&
                     (dreq.addr <= iopage_pkg::ROM_LAST);
   assign offset = dreq.addr - iopage_pkg::ROM_FIRST;
   assign idx    = offset[8:1];              // window is 256 words.

   always_comb
   begin
      case (idx)
         8'd0:    fetch = 16'o010000;        // mov r0,r0, used as nop.
         8'd1:    fetch = 16'o012706;        // mov #2000,sp.
         8'd2:    fetch = 16'o002000;
         8'd3:    fetch = 16'o012700;        // mov #0,r0, unit number.
         8'd4:    fetch = 16'o000000;
         8'd5:    fetch = 16'o010003;        // mov r0,r3.
         8'd6:    fetch = 16'o000303;        // swab r3.
         8'd7:    fetch = 16'o006303;        // asl r3, five times, unit into da<15:13>.
         8'd8:    fetch = 16'o006303;
         8'd9:    fetch = 16'o006303;
         8'd10:   fetch = 16'o006303;
         8'd11:   fetch = 16'o006303;
         8'd12:   fetch = 16'o012701;        // mov #rkda,r1.
         8'd13:   fetch = 16'o177412;
         8'd14:   fetch = 16'o010311;        // mov r3,(r1), disk address.
         8'd15:   fetch = 16'o005041;        // clr -(r1), bus address.
         8'd16:   fetch = 16'o012741;        // mov #-512.,-(r1), word count.
         8'd17:   fetch = 16'o177000;
         8'd18:   fetch = 16'o012741;        // mov #read+go,-(r1).
         8'd19:   fetch = 16'o000005;
         8'd20:   fetch = 16'o005002;        // clr r2.
         8'd21:   fetch = 16'o005003;        // clr r3.
         8'd22:   fetch = 16'o012704;        // mov #start+20,r4.
         8'd23:   fetch = 16'o002020;
         8'd24:   fetch = 16'o005005;        // clr r5.
         8'd25:   fetch = 16'o105711;        // tstb (r1), wait for done.
         8'd26:   fetch = 16'o100376;        // bpl .-2.
         8'd27:   fetch = 16'o105011;        // clrb (r1).
         8'd28:   fetch = 16'o005007;        // clr pc, enter the loaded block.
         default: fetch = 16'o000000;        // rest of the window reads zero.
      endcase
   end

   // writes are accepted and dropped.
   assign rsp.hit   = in_range && (dreq.rd || dreq.wr);
   assign rsp.rdata = (in_range && dreq.rd) ? fetch : '0;

endmodule

// ==== common/iopage_pkg.sv ====
// shared types, bus structs and the fixed address map of the i/o page slave.
// every design file refers to these by scoped name.
package iopage_pkg;

   typedef logic [12:0] iopage_addr_t;       // i/o page byte address.
   typedef logic [15:0] word_t;              // bus data word.
   typedef logic [1:0]  lanes_t;             // bit 0 low byte, bit 1 high byte.
   typedef logic [7:0]  rom_idx_t;           // word index inside the 512 byte rom window.

   // host request as presented on the top level port.
   typedef struct packed {
      iopage_addr_t addr;                    // byte address.
      word_t        wdata;                   // odd byte writes carry data in 15:8.
      logic         rd;                      // one cycle read strobe.
      logic         wr;                      // one cycle write strobe.
      logic         byte_op;                 // byte access when set.
   } iopage_req_t;

   // registered request, fanned out to every device.
   typedef struct packed {
      iopage_addr_t addr;
      word_t        wdata;                   // byte already placed in its lane.
      lanes_t       lanes;                   // byte lanes to write.
      logic         rd;
      logic         wr;
   } dev_req_t;

   // one device's answer.
   typedef struct packed {
      logic  hit;                            // address decoded with a strobe.
      word_t rdata;                          // full word, zero unless reading.
   } dev_rsp_t;

   // boot rom window, rk11 bootstrap lives here.
   localparam iopage_addr_t ROM_FIRST = 13'o13000;
   localparam iopage_addr_t ROM_LAST  = 13'o13776;

   // scratch register banks.
   localparam int NUM_BANKS   = 4;
   localparam int BANK_WORDS  = 8;
   localparam int BANK_IDX_W  = $clog2(BANK_WORDS);
   localparam iopage_addr_t BANK_BASE = 13'o17500;
   localparam int BANK_STRIDE = 16;          // bytes between bank bases.

   typedef logic [BANK_IDX_W-1:0] bank_idx_t; // word index inside one bank.

   // device 0 is the rom, banks follow.
   localparam int NUM_DEVS = NUM_BANKS + 1;

endpackage

// ==== flist.f ====
common/iopage_pkg.sv
bootrom/bootrom.sv
source/iopage_request_stage.sv
source/scratch_bank.sv
source/iopage_response_stage.sv
source/iopage_subsystem.sv
tb/iopage_clkgen.sv
tb/iopage_chk.sv
tb/tb_iopage.sv

// ==== source/iopage_request_stage.sv ====
// registers the host request once and derives byte lanes for the devices.
// sole driver of the device side request.
`timescale 1ns/1ps

module iopage_request_stage
(
   input  logic                    clk,
   input  logic                    rst,
   input  iopage_pkg::iopage_req_t req,
   output iopage_pkg::dev_req_t    dreq,
   output logic                    dbyte
);

   iopage_pkg::lanes_t lanes_n;              // lane enables for this request.
   iopage_pkg::word_t  wdata_n;              // write data with byte in its lane.

   always_comb
   begin
      if (!req.byte_op)
      begin
         lanes_n = 2'b11;                    // word access.
         wdata_n = req.wdata;
      end
      else if (req.addr[0])
      begin
         lanes_n = 2'b10;                    // odd byte, data already in 15:8.
         wdata_n = {req.wdata[15:8], req.wdata[15:8]};
      end
      else
      begin
         lanes_n = 2'b01;                    // even byte.
         wdata_n = {req.wdata[7:0], req.wdata[7:0]};
      end
   end

   always_ff @(posedge clk)
   begin
      dreq.addr  <= req.addr;
      dreq.wdata <= wdata_n;
      dreq.lanes <= lanes_n;
      if (rst)
      begin
         dreq.rd <= 1'b0;
         dreq.wr <= 1'b0;
         dbyte   <= 1'b0;
      end
      else
      begin
         dreq.rd <= req.rd;
         dreq.wr <= req.wr;
         dbyte   <= req.byte_op & req.addr[0]; // high byte select for reads.
      end
   end

endmodule

// ==== source/iopage_response_stage.sv ====
// merges the device answers, picks the byte for byte reads, flags misses.
// result is registered one edge after the devices see the request.
`timescale 1ns/1ps

module iopage_response_stage
(
   input  logic                 clk,
   input  logic                 rst,
   input  iopage_pkg::dev_rsp_t rsp [iopage_pkg::NUM_DEVS],
   input  logic                 rd,
   input  logic                 wr,
   input  logic                 dbyte,
   input  logic                 byte_op,
   output iopage_pkg::word_t    rdata,
   output logic                 rd_valid,
   output logic                 nxm
);

   logic              hit_any;               // some device decoded the address.
   iopage_pkg::word_t rd_word;               // or of all device data.
   iopage_pkg::word_t rd_out;                // word or extracted byte.

   // only the hitting device drives nonzero data, so an or is enough.
   always_comb
   begin
      hit_any = 1'b0;
      rd_word = '0;
      for (int i = 0; i < iopage_pkg::NUM_DEVS; i++)
      begin
         hit_any = hit_any | rsp[i].hit;
         rd_word = rd_word | rsp[i].rdata;
      end
   end

   // byte reads come back zero extended in 7:0.
   assign rd_out = byte_op ? {8'h00, (dbyte ? rd_word[15:8] : rd_word[7:0])} : rd_word;

   always_ff @(posedge clk)
   begin
      if (rd)
      begin
         rdata <= rd_out;                    // held until the next read.
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rd_valid <= 1'b0;
         nxm      <= 1'b0;
      end
      else
      begin
         rd_valid <= rd & hit_any;
         nxm      <= (rd | wr) & ~hit_any;   // nobody answered.
      end
   end

endmodule

// ==== source/iopage_subsystem.sv ====
// i/o page slave top: request register, rom, scratch banks, response register.
// fixed two edge read latency, one request per cycle.
`timescale 1ns/1ps

module iopage_subsystem
(
   input  logic                    clk,
   input  logic                    rst,
   input  iopage_pkg::iopage_req_t req,
   output iopage_pkg::word_t       rdata,
   output logic                    rd_valid,
   output logic                    nxm
);

   iopage_pkg::dev_req_t dreq;               // registered request to all devices.
   logic                 dbyte;              // registered high byte select.
   iopage_pkg::dev_rsp_t rsp [iopage_pkg::NUM_DEVS]; // index 0 is the rom.

   iopage_request_stage i_iopage_request_stage
   (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .dreq  (dreq),
      .dbyte (dbyte)
   );

   bootrom i_bootrom
   (
      .dreq (dreq),
      .rsp  (rsp[0])
   );

   for (genvar i = 0; i < iopage_pkg::NUM_BANKS; i++)
   begin : g_bank
      scratch_bank #(.bank_index(i)) i_scratch_bank
      (
         .clk  (clk),
         .rst  (rst),
         .dreq (dreq),
         .rsp  (rsp[i+1])
      );
   end

   // a byte request never enables both lanes.
   iopage_response_stage i_iopage_response_stage
   (
      .clk      (clk),
      .rst      (rst),
      .rsp      (rsp),
      .rd       (dreq.rd),
      .wr       (dreq.wr),
      .dbyte    (dbyte),
      .byte_op  (~&dreq.lanes),
      .rdata    (rdata),
      .rd_valid (rd_valid),
      .nxm      (nxm)
   );

endmodule

// ==== source/scratch_bank.sv ====
// one bank of eight scratch words with byte lane writes.
// bank_index picks its slot above the common bank base.
`timescale 1ns/1ps

module scratch_bank
#(
   parameter int bank_index = 0
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  iopage_pkg::dev_req_t dreq,
   output iopage_pkg::dev_rsp_t rsp
);

   iopage_pkg::word_t        mem [iopage_pkg::BANK_WORDS];
   iopage_pkg::iopage_addr_t offset;         // byte offset from this bank's base.
   iopage_pkg::bank_idx_t    idx;
   logic                     in_range;

   // addresses below the base wrap to large offsets and miss.
   assign offset   = dreq.addr - iopage_pkg::iopage_addr_t'(iopage_pkg::BANK_BASE +
                     bank_index * iopage_pkg::BANK_STRIDE);
   assign in_range = offset < iopage_pkg::iopage_addr_t'(iopage_pkg::BANK_STRIDE);
   assign idx      = offset[iopage_pkg::BANK_IDX_W:1];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < iopage_pkg::BANK_WORDS; i++)
         begin
            mem[i] <= '0;                    // bank reads zero after reset.
         end
      end
      else if (in_range && dreq.wr)
      begin
         if (dreq.lanes[0])
         begin
            mem[idx][7:0] <= dreq.wdata[7:0];
         end
         if (dreq.lanes[1])
         begin
            mem[idx][15:8] <= dreq.wdata[15:8];
         end
      end
   end

   assign rsp.hit   = in_range && (dreq.rd || dreq.wr);
   assign rsp.rdata = (in_range && dreq.rd) ? mem[idx] : '0; // same cycle read.

endmodule

// ==== tb/iopage_chk.sv ====
// bus protocol assertions, bound into the i/o page top level.
// answer flags are checked against the host read strobe two edges back.
`timescale 1ns/1ps

module iopage_chk
(
   input logic clk,
   input logic rst,
   input logic req_rd,
   input logic rd_valid,
   input logic nxm
);

   int fail_count = 0;                       // number of failed assertions.

   // a request is answered either with data or as a miss.
   exclusive_answer: assert property (@(posedge clk) disable iff (rst) !(rd_valid && nxm))
   else
   begin
      $error("rd_valid and nxm high in the same cycle");
      fail_count++;
   end

   valid_after_read: assert property (@(posedge clk) disable iff (rst)
                                      rd_valid |-> $past(req_rd, 2))
   else
   begin
      $error("rd_valid without a read strobe two edges earlier");
      fail_count++;
   end

   // reads taken outside reset must come back, with data or nxm.
   read_answered: assert property (@(posedge clk) disable iff (rst)
                                   ($past(req_rd, 2) && !$past(rst, 2) && !$past(rst, 1))
                                   |-> (rd_valid || nxm))
   else
   begin
      $error("read strobe not answered two edges later");
      fail_count++;
   end

   nxm_after_rst: assert property (@(posedge clk) rst |=> !nxm)
   else
   begin
      $error("nxm high right after reset");
      fail_count++;
   end

endmodule

bind iopage_subsystem iopage_chk i_iopage_chk
(
   .clk      (clk),
   .rst      (rst),
   .req_rd   (req.rd),
   .rd_valid (rd_valid),
   .nxm      (nxm)
);

// ==== tb/iopage_clkgen.sv ====
// free running testbench clock, 20 ns period.
`timescale 1ns/1ps

module iopage_clkgen
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;                            // first rising edge at 10 ns.
      forever #10 clk = ~clk;
   end

endmodule

// ==== tb/tb_iopage.sv ====
// directed testbench for the i/o page slave: rom, scratch banks, misses, reset.
// requests go in on falling edges, answers are sampled two falling edges later.
`timescale 1ns/1ps

module tb_iopage;

   localparam int PLANNED_ACCESSES = 31 + 14 + 64 + 20 + 14 + 36; // tests 1 to 6.
   localparam int WATCHDOG_NS      = 2000 + 40 * PLANNED_ACCESSES;

   // rk11 bootstrap words, the expected rom contents.
   localparam iopage_pkg::word_t BOOT_IMAGE [29] = '{
      16'o010000, 16'o012706, 16'o002000, 16'o012700, 16'o000000,
      16'o010003, 16'o000303, 16'o006303, 16'o006303, 16'o006303,
      16'o006303, 16'o006303, 16'o012701, 16'o177412, 16'o010311,
      16'o005041, 16'o012741, 16'o177000, 16'o012741, 16'o000005,
      16'o005002, 16'o005003, 16'o012704, 16'o002020, 16'o005005,
      16'o105711, 16'o100376, 16'o105011, 16'o005007};

   logic                    clk;
   logic                    rst;
   iopage_pkg::iopage_req_t req;
   iopage_pkg::word_t       rdata;
   logic                    rd_valid;
   logic                    nxm;

   iopage_pkg::word_t bank_model [iopage_pkg::NUM_BANKS][iopage_pkg::BANK_WORDS];
   int seed = 56;
   int checks = 0;
   int errors = 0;
   int test_errors = 0;                      // errors of the running test.
   int fired;                                // assertion failures in the checker.

   iopage_clkgen i_iopage_clkgen (.clk(clk));

   iopage_subsystem i_iopage_subsystem
   (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .rdata    (rdata),
      .rd_valid (rd_valid),
      .nxm      (nxm)
   );

   function automatic iopage_pkg::iopage_addr_t bank_addr(input int bank, input int word);
      return iopage_pkg::iopage_addr_t'(iopage_pkg::BANK_BASE +
                                        bank * iopage_pkg::BANK_STRIDE + word * 2);
   endfunction

   task automatic compare_word(input string name, input iopage_pkg::word_t got,
                               input iopage_pkg::word_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("** Error @ %0t: %s expected %h got %h", $time, name, exp, got);
         test_errors++;
      end
   endtask

   task automatic expect_flag(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("** Error @ %0t: %s expected %b got %b", $time, name, exp, got);
         test_errors++;
      end
   endtask

   // one request; returns on the falling edge after its answer is registered.
   task automatic bus_cycle(input iopage_pkg::iopage_addr_t addr, input iopage_pkg::word_t wdata,
                            input logic rd, input logic wr, input logic byte_op,
                            output iopage_pkg::word_t data, output logic valid,
                            output logic miss);
      req.addr    = addr;
      req.wdata   = wdata;
      req.rd      = rd;
      req.wr      = wr;
      req.byte_op = byte_op;
      @(negedge clk);
      req = '0;                              // strobes last one cycle.
      @(negedge clk);
      data  = rdata;
      valid = rd_valid;
      miss  = nxm;
   endtask

   task automatic read_and_compare(input iopage_pkg::iopage_addr_t addr, input logic byte_op,
                                   input iopage_pkg::word_t exp,
                                   output iopage_pkg::word_t data);
      logic valid;
      logic miss;
      bus_cycle(addr, '0, 1'b1, 1'b0, byte_op, data, valid, miss);
      expect_flag("rd_valid", valid, 1'b1);
      expect_flag("nxm", miss, 1'b0);
      compare_word("rdata", data, exp);
   endtask

   task automatic write_accepted(input iopage_pkg::iopage_addr_t addr,
                                 input iopage_pkg::word_t wdata, input logic byte_op);
      iopage_pkg::word_t data;
      logic              valid;
      logic              miss;
      bus_cycle(addr, wdata, 1'b0, 1'b1, byte_op, data, valid, miss);
      expect_flag("rd_valid", valid, 1'b0);
      expect_flag("nxm", miss, 1'b0);
   endtask

   task automatic access_missed(input iopage_pkg::iopage_addr_t addr, input logic rd);
      iopage_pkg::word_t data;
      logic              valid;
      logic              miss;
      bus_cycle(addr, 16'hdead, rd, ~rd, 1'b0, data, valid, miss);
      expect_flag("rd_valid", valid, 1'b0);
      expect_flag("nxm", miss, 1'b1);
   endtask

   task automatic report_test(input string name);
      $display("%s: %0d errors", name, test_errors);
      errors      = errors + test_errors;
      test_errors = 0;
   endtask

   task automatic rom_word_reads();
      iopage_pkg::word_t data;
      for (int i = 0; i < 29; i++)
      begin
         read_and_compare(iopage_pkg::iopage_addr_t'(iopage_pkg::ROM_FIRST + 2 * i), 1'b0,
                          BOOT_IMAGE[i], data);
      end
      read_and_compare(iopage_pkg::iopage_addr_t'(iopage_pkg::ROM_FIRST + 60), 1'b0, '0, data);
      read_and_compare(iopage_pkg::ROM_LAST, 1'b0, '0, data); // end of the window.
      report_test("rom word reads");
   endtask

   task automatic rom_byte_reads();
      int                       picks [6] = '{1, 2, 13, 17, 26, 28};
      iopage_pkg::iopage_addr_t addr;
      iopage_pkg::word_t        data;
      foreach (picks[p])
      begin
         addr = iopage_pkg::iopage_addr_t'(iopage_pkg::ROM_FIRST + 2 * picks[p]);
         read_and_compare(addr, 1'b1, {8'h00, BOOT_IMAGE[picks[p]][7:0]}, data);
         read_and_compare(addr + 13'd1, 1'b1, {8'h00, BOOT_IMAGE[picks[p]][15:8]}, data);
      end
      addr = iopage_pkg::iopage_addr_t'(iopage_pkg::ROM_FIRST + 26);
      write_accepted(addr, 16'hffff, 1'b0);  // rom swallows the write.
      read_and_compare(addr, 1'b0, BOOT_IMAGE[13], data);
      report_test("rom byte reads");
   endtask

   task automatic bank_word_writes();
      iopage_pkg::word_t seen [iopage_pkg::NUM_BANKS][iopage_pkg::BANK_WORDS];
      iopage_pkg::word_t value;
      for (int b = 0; b < iopage_pkg::NUM_BANKS; b++)
      begin
         for (int w = 0; w < iopage_pkg::BANK_WORDS; w++)
         begin
            value        = iopage_pkg::word_t'($random(seed));
            value[15:14] = b[1:0];           // bank number tag keeps neighbours apart.
            write_accepted(bank_addr(b, w), value, 1'b0);
            bank_model[b][w] = value;
         end
      end
      foreach (seen[b, w])
      begin
         read_and_compare(bank_addr(b, w), 1'b0, bank_model[b][w], seen[b][w]);
      end
      for (int b = 0; b + 1 < iopage_pkg::NUM_BANKS; b++)
      begin
         for (int w = 0; w < iopage_pkg::BANK_WORDS; w++)
         begin
            checks++;
            assert (seen[b][w] !== seen[b+1][w])
            else
            begin
               $display("bank %0d word %0d reads the same as bank %0d", b, w, b + 1);
               test_errors++;
            end
         end
      end
      report_test("bank word writes");
   endtask

   task automatic bank_byte_writes();
      iopage_pkg::word_t value;
      iopage_pkg::word_t data;
      int                w;
      for (int b = 0; b < iopage_pkg::NUM_BANKS; b++)
      begin
         w     = 2 * b + 1;
         value = iopage_pkg::word_t'($random(seed));
         write_accepted(bank_addr(b, w), value, 1'b0);
         bank_model[b][w] = value;
         value = iopage_pkg::word_t'($random(seed)); // odd byte rides in 15:8.
         write_accepted(bank_addr(b, w) + 13'd1, value, 1'b1);
         bank_model[b][w][15:8] = value[15:8];
         read_and_compare(bank_addr(b, w), 1'b0, bank_model[b][w], data);
         value = iopage_pkg::word_t'($random(seed));
         write_accepted(bank_addr(b, w), value, 1'b1);
         bank_model[b][w][7:0] = value[7:0];
         read_and_compare(bank_addr(b, w), 1'b0, bank_model[b][w], data);
      end
      report_test("bank byte writes");
   endtask

   task automatic missing_devices();
      iopage_pkg::iopage_addr_t holes [3] = '{13'o12776, 13'o15000, 13'o17600};
      foreach (holes[h])
      begin
         access_missed(holes[h], 1'b1);
         access_missed(holes[h], 1'b0);
      end
      // back to back reads of bank 0, answers two cycles behind the requests.
      for (int k = 0; k < iopage_pkg::BANK_WORDS + 2; k++)
      begin
         if (k >= 2)
         begin
            expect_flag("rd_valid", rd_valid, 1'b1);
            expect_flag("nxm", nxm, 1'b0);
            compare_word("rdata", rdata, bank_model[0][k-2]);
         end
         req = '0;
         if (k < iopage_pkg::BANK_WORDS)
         begin
            req.addr = bank_addr(0, k);
            req.rd   = 1'b1;
         end
         @(negedge clk);
      end
      report_test("missing devices");
   endtask

   task automatic reset_clears_banks();
      iopage_pkg::word_t data;
      for (int b = 0; b < iopage_pkg::NUM_BANKS; b++)
      begin
         data = iopage_pkg::word_t'($random(seed)) | 16'h0001; // never zero.
         write_accepted(bank_addr(b, 0), data, 1'b0);
      end
      rst = 1'b1;
      for (int k = 0; k < 16; k++)
      begin
         req      = '0;
         req.addr = bank_addr(0, 0);
         req.rd   = 1'b1;                    // reads under reset get no answer.
         @(negedge clk);
         expect_flag("rd_valid", rd_valid, 1'b0);
      end
      req = '0;
      rst = 1'b0;
      foreach (bank_model[b, w])
      begin
         bank_model[b][w] = '0;
         read_and_compare(bank_addr(b, w), 1'b0, bank_model[b][w], data);
      end
      report_test("reset clears banks");
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("Regression failed");
      $finish;
   end

   initial
   begin
      rst = 1'b1;
      req = '0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      rom_word_reads();
      rom_byte_reads();
      bank_word_writes();
      bank_byte_writes();
      missing_devices();
      reset_clears_banks();
      fired = i_iopage_subsystem.i_iopage_chk.fail_count;
      $display("tests 6, checks %0d, errors %0d, assertion failures %0d", checks, errors, fired);
      if (errors == 0 && fired == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
